// File: rtl/cpu_pkg.sv
package cpu_pkg;

	// **************************************************
	// widths and sizes
	// **************************************************
	localparam int WORD_W     = 16;   // data and instruction word
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS   = 16;
	localparam int MEM_ADDR_W = 8;
	localparam int MEM_DEPTH  = 256;  // words per memory

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	// **************************************************
	// instruction encodings
	// **************************************************
	// opcode lives in instr[15:12]
	// 0111 and 1100..1110 are unused and decode as nop
	typedef enum logic [3:0] {
		OP_ADD = 4'b0000,
		OP_SUB = 4'b0001,
		OP_AND = 4'b0010,
		OP_OR  = 4'b0011,
		OP_XOR = 4'b0100,
		OP_SLL = 4'b0101,
		OP_SRL = 4'b0110,
		OP_LW  = 4'b1000,  // rd <- mem[base + off]
		OP_SW  = 4'b1001,  // mem[base + off] <- rd
		OP_LHB = 4'b1010,  // rd[15:8] <- imm8
		OP_LLB = 4'b1011,  // rd[7:0] <- imm8
		OP_HLT = 4'b1111
	} opcode_e;

	// ten alu functions so four bits wide
	typedef enum logic [3:0] {
		ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_SLL, ALU_SRL, ALU_LHB, ALU_LLB
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_REG,  // value read in ID
		FWD_MEM,  // EX/MEM result
		FWD_WB    // MEM/WB result
	} fwd_sel_e;

	localparam word_t NOP_INSTR = 16'h7000;  // unused opcode

endpackage

// File: rtl/alu.sv
`timescale 1ns/100ps

module alu (
	input  cpu_pkg::alu_op_e op,
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	output cpu_pkg::word_t   result
);
	import cpu_pkg::*;

	logic [3:0] shamt;

	assign shamt = b[3:0];  // shifts use low nibble only

	always_comb begin
		case (op)
			ALU_ADD:
				result = a + b;  // also LW/SW address
			ALU_SUB:
				result = a - b;  // wraps
			ALU_AND:
				result = a & b;
			ALU_OR:
				result = a | b;
			ALU_XOR:
				result = a ^ b;
			ALU_SLL:
				result = a << shamt;
			ALU_SRL:
				result = a >> shamt;  // logical, zero fill
			// byte loads
			ALU_LHB:
				result = {b[7:0], a[7:0]};
			ALU_LLB:
				result = {a[WORD_W-1:8], b[7:0]};
			ALU_PASS:
				result = a;
			default:
				result = a;
		endcase
	end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/100ps

module register_file (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::reg_addr_t rd_addr_a,
	input  cpu_pkg::reg_addr_t rd_addr_b,
	output cpu_pkg::word_t     rd_data_a,
	output cpu_pkg::word_t     rd_data_b,
	input  logic               wr_en,
	input  cpu_pkg::reg_addr_t wr_addr,
	input  cpu_pkg::word_t     wr_data
);
	import cpu_pkg::*;

	word_t regs [NUM_REGS];
	logic  wr_ok;  // real write, r0 excluded

	assign wr_ok = wr_en && (wr_addr != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_ok) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// WB write shows up in the same cycle's ID read
	always_comb begin
		if (wr_ok && (wr_addr == rd_addr_a))
			rd_data_a = wr_data;
		else
			rd_data_a = regs[rd_addr_a];  // regs[0] stays zero
	end

	always_comb begin
		if (wr_ok && (wr_addr == rd_addr_b))
			rd_data_b = wr_data;
		else
			rd_data_b = regs[rd_addr_b];
	end

endmodule

// File: rtl/forwarding_unit.sv
`timescale 1ns/100ps

module forwarding_unit (
	input  cpu_pkg::reg_addr_t ex_src_a,
	input  cpu_pkg::reg_addr_t ex_src_b,
	input  cpu_pkg::reg_addr_t mem_dest,
	input  logic               mem_reg_write,
	input  cpu_pkg::reg_addr_t wb_dest,
	input  logic               wb_reg_write,
	output cpu_pkg::fwd_sel_e  fwd_a,
	output cpu_pkg::fwd_sel_e  fwd_b
);
	import cpu_pkg::*;

	// youngest producer wins, r0 never forwarded
	function automatic fwd_sel_e pick(reg_addr_t src);
		if (src == '0)
			return FWD_REG;
		if (mem_reg_write && (mem_dest == src))
			return FWD_MEM;
		if (wb_reg_write && (wb_dest == src))
			return FWD_WB;
		return FWD_REG;
	endfunction

	assign fwd_a = pick(ex_src_a);
	assign fwd_b = pick(ex_src_b);

	always_comb begin
		a_fwd_en : assert #0 (!((fwd_a == FWD_MEM || fwd_b == FWD_MEM) && !mem_reg_write) &&
			!((fwd_a == FWD_WB || fwd_b == FWD_WB) && !wb_reg_write))
			else $error("forwarding from a stage that does not write");
	end

endmodule

// File: rtl/hazard_detection.sv
`timescale 1ns/100ps

module hazard_detection (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::word_t     if_id_instr,
	input  cpu_pkg::reg_addr_t id_ex_dest,
	input  logic               id_ex_mem_read,
	output logic               stall,
	output logic               halt_seen
);
	import cpu_pkg::*;

	opcode_e   id_op;
	logic      id_lw, id_sw, id_byte, id_hlt;
	reg_addr_t id_rs, id_rt;
	logic      ld_hazard;
	logic      ld_stall;
	logic      blocker;  // high the cycle after a load-use stall

	// **************************************************
	// source fields of the ID instruction
	// **************************************************
	assign id_op   = opcode_e'(if_id_instr[15:12]);
	assign id_lw   = (id_op == OP_LW);
	assign id_sw   = (id_op == OP_SW);
	assign id_byte = (id_op == OP_LHB) || (id_op == OP_LLB);
	assign id_hlt  = (id_op == OP_HLT);

	assign id_rs = (id_sw || id_byte) ? if_id_instr[11:8] : if_id_instr[7:4];
	assign id_rt = (id_sw || id_lw) ? if_id_instr[7:4] : if_id_instr[3:0];

	// **************************************************
	// load-use
	// **************************************************
	assign ld_hazard = id_ex_mem_read && ((id_rs == id_ex_dest) || (id_rt == id_ex_dest));
	assign ld_stall  = ld_hazard && !blocker;  // one bubble per pair

	always_ff @(posedge clk) begin
		if (reset)
			blocker <= 1'b0;
		else
			blocker <= ld_stall;
	end

	// **************************************************
	// halt
	// **************************************************
	// latch only once HLT really leaves ID
	always_ff @(posedge clk) begin
		if (reset)
			halt_seen <= 1'b0;
		else if (id_hlt && !ld_stall)
			halt_seen <= 1'b1;
	end

	assign stall = ld_stall || halt_seen;  // halt_seen freezes fetch for good

	// bubble must clear the load out of ID/EX
	a_ld_stall_single : assert property (@(posedge clk) disable iff (reset)
		ld_hazard |=> !ld_hazard || halt_seen);

	a_halt_sticky : assert property (@(posedge clk) disable iff (reset)
		halt_seen |=> halt_seen);

endmodule

// File: rtl/control_unit.sv
`timescale 1ns/100ps

module control_unit (
	input  cpu_pkg::word_t     instr,
	output cpu_pkg::alu_op_e   alu_op,
	output logic               use_imm,
	output cpu_pkg::word_t     imm,
	output cpu_pkg::reg_addr_t src_a,
	output cpu_pkg::reg_addr_t src_b,
	output cpu_pkg::reg_addr_t dest,
	output logic               reg_write,
	output logic               mem_read,
	output logic               mem_write,
	output logic               is_halt
);
	import cpu_pkg::*;

	opcode_e op;
	logic    rr_op;  // three-register alu form

	assign op = opcode_e'(instr[15:12]);

	always_comb begin
		alu_op    = ALU_PASS;
		use_imm   = 1'b0;
		imm       = '0;
		src_a     = '0;
		src_b     = '0;
		dest      = instr[11:8];  // same field for every writer
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		is_halt   = 1'b0;
		rr_op     = 1'b0;
		case (op)
			OP_ADD: begin alu_op = ALU_ADD; rr_op = 1'b1; end
			OP_SUB: begin alu_op = ALU_SUB; rr_op = 1'b1; end
			OP_AND: begin alu_op = ALU_AND; rr_op = 1'b1; end
			OP_OR:  begin alu_op = ALU_OR;  rr_op = 1'b1; end
			OP_XOR: begin alu_op = ALU_XOR; rr_op = 1'b1; end
			OP_SLL: begin alu_op = ALU_SLL; rr_op = 1'b1; end
			OP_SRL: begin alu_op = ALU_SRL; rr_op = 1'b1; end
			OP_LW, OP_SW: begin
				alu_op    = ALU_ADD;                   // base + word offset
				use_imm   = 1'b1;
				imm       = {{(WORD_W-4){1'b0}}, instr[3:0]};
				src_a     = instr[7:4];                // base
				src_b     = (op == OP_SW) ? instr[11:8] : '0;  // store data
				reg_write = (op == OP_LW);
				mem_read  = (op == OP_LW);
				mem_write = (op == OP_SW);
			end
			OP_LHB, OP_LLB: begin
				alu_op    = (op == OP_LHB) ? ALU_LHB : ALU_LLB;
				use_imm   = 1'b1;
				imm       = {{(WORD_W-8){1'b0}}, instr[7:0]};
				src_a     = instr[11:8];  // old rd value, one byte survives
				reg_write = 1'b1;
			end
			OP_HLT: is_halt = 1'b1;
			default: ;  // nop
		endcase
		if (rr_op) begin
			src_a     = instr[7:4];
			src_b     = instr[3:0];
			reg_write = 1'b1;
		end
	end

endmodule

// File: rtl/cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
	input  logic               clk,
	input  logic               reset,
	input  logic               load_en,
	input  logic               load_dmem,
	input  cpu_pkg::mem_addr_t load_addr,
	input  cpu_pkg::word_t     load_data,
	output logic               wb_valid,
	output cpu_pkg::reg_addr_t wb_reg,
	output cpu_pkg::word_t     wb_data,
	output logic               halted
);
	import cpu_pkg::*;

	word_t     imem [MEM_DEPTH];
	word_t     dmem [MEM_DEPTH];

	mem_addr_t pc;
	word_t     if_id_instr;
	logic      stall, halt_seen;

	// decode
	alu_op_e   id_alu_op;
	logic      id_use_imm;
	word_t     id_imm;
	reg_addr_t id_src_a, id_src_b, id_dest;
	logic      id_reg_write, id_mem_read, id_mem_write, id_is_halt;
	word_t     id_rdata_a, id_rdata_b;

	// ID/EX
	alu_op_e   id_ex_alu_op;
	logic      id_ex_use_imm;
	word_t     id_ex_imm;
	reg_addr_t id_ex_src_a, id_ex_src_b, id_ex_dest;
	logic      id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_is_halt;
	word_t     id_ex_rdata_a, id_ex_rdata_b;

	// EX
	fwd_sel_e  fwd_a, fwd_b;
	word_t     ex_a, ex_b_reg, ex_b, ex_result;

	// EX/MEM
	word_t     ex_mem_result, ex_mem_store;
	reg_addr_t ex_mem_dest;
	logic      ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_is_halt;
	mem_addr_t dmem_addr;
	word_t     dmem_rdata;

	// MEM/WB
	word_t     mem_wb_data;
	reg_addr_t mem_wb_dest;
	logic      mem_wb_reg_write, mem_wb_is_halt;
	logic      halted_q;

	function automatic word_t fwd_val(fwd_sel_e sel, word_t reg_val);
		case (sel)
			FWD_MEM: return ex_mem_result;
			FWD_WB:  return mem_wb_data;
			default: return reg_val;
		endcase
	endfunction

	// **************************************************
	// IF
	// **************************************************
	always_ff @(posedge clk) begin
		if (reset && load_en && !load_dmem)
			imem[load_addr] <= load_data;  // load port only under reset
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc          <= '0;
			if_id_instr <= NOP_INSTR;
		end else if (!stall) begin  // stall holds pc and IF/ID
			pc          <= pc + 1'b1;
			if_id_instr <= imem[pc];
		end
	end

	// **************************************************
	// ID
	// **************************************************
	control_unit ctrl0 (
		.instr(if_id_instr), .alu_op(id_alu_op), .use_imm(id_use_imm), .imm(id_imm),
		.src_a(id_src_a), .src_b(id_src_b), .dest(id_dest), .reg_write(id_reg_write),
		.mem_read(id_mem_read), .mem_write(id_mem_write), .is_halt(id_is_halt)
	);

	hazard_detection hzd0 (
		.clk(clk), .reset(reset), .if_id_instr(if_id_instr), .id_ex_dest(id_ex_dest),
		.id_ex_mem_read(id_ex_mem_read), .stall(stall), .halt_seen(halt_seen)
	);

	register_file rf0 (
		.clk(clk), .reset(reset), .rd_addr_a(id_src_a), .rd_addr_b(id_src_b),
		.rd_data_a(id_rdata_a), .rd_data_b(id_rdata_b), .wr_en(mem_wb_reg_write),
		.wr_addr(mem_wb_dest), .wr_data(mem_wb_data)
	);

	always_ff @(posedge clk) begin
		if (reset || stall) begin  // bubble
			id_ex_reg_write <= 1'b0;
			id_ex_mem_read  <= 1'b0;
			id_ex_mem_write <= 1'b0;
			id_ex_is_halt   <= 1'b0;
		end else begin
			id_ex_reg_write <= id_reg_write;
			id_ex_mem_read  <= id_mem_read;
			id_ex_mem_write <= id_mem_write;
			id_ex_is_halt   <= id_is_halt;
		end
	end

	always_ff @(posedge clk) begin
		id_ex_alu_op  <= id_alu_op;
		id_ex_use_imm <= id_use_imm;
		id_ex_imm     <= id_imm;
		id_ex_src_a   <= id_src_a;
		id_ex_src_b   <= id_src_b;
		id_ex_dest    <= id_dest;
		id_ex_rdata_a <= id_rdata_a;
		id_ex_rdata_b <= id_rdata_b;
	end

	// **************************************************
	// EX
	// **************************************************
	forwarding_unit fwd0 (
		.ex_src_a(id_ex_src_a), .ex_src_b(id_ex_src_b), .mem_dest(ex_mem_dest),
		.mem_reg_write(ex_mem_reg_write), .wb_dest(mem_wb_dest),
		.wb_reg_write(mem_wb_reg_write), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	assign ex_a     = fwd_val(fwd_a, id_ex_rdata_a);
	assign ex_b_reg = fwd_val(fwd_b, id_ex_rdata_b);  // store data path too
	assign ex_b     = id_ex_use_imm ? id_ex_imm : ex_b_reg;

	alu alu0 (.op(id_ex_alu_op), .a(ex_a), .b(ex_b), .result(ex_result));

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem_reg_write <= 1'b0;
			ex_mem_mem_read  <= 1'b0;
			ex_mem_mem_write <= 1'b0;
			ex_mem_is_halt   <= 1'b0;
		end else begin
			ex_mem_reg_write <= id_ex_reg_write;
			ex_mem_mem_read  <= id_ex_mem_read;
			ex_mem_mem_write <= id_ex_mem_write;
			ex_mem_is_halt   <= id_ex_is_halt;
		end
		ex_mem_result <= ex_result;
		ex_mem_store  <= ex_b_reg;
		ex_mem_dest   <= id_ex_dest;
	end

	// **************************************************
	// MEM and WB
	// **************************************************
	assign dmem_addr  = ex_mem_result[MEM_ADDR_W-1:0];
	assign dmem_rdata = dmem[dmem_addr];  // async read

	always_ff @(posedge clk) begin
		if (reset) begin
			if (load_en && load_dmem)
				dmem[load_addr] <= load_data;
		end else if (ex_mem_mem_write) begin
			dmem[dmem_addr] <= ex_mem_store;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb_reg_write <= 1'b0;
			mem_wb_is_halt   <= 1'b0;
			halted_q         <= 1'b0;
		end else begin
			mem_wb_reg_write <= ex_mem_reg_write;
			mem_wb_is_halt   <= ex_mem_is_halt;
			halted_q         <= halted_q || mem_wb_is_halt;  // sticky
		end
		mem_wb_data <= ex_mem_mem_read ? dmem_rdata : ex_mem_result;
		mem_wb_dest <= ex_mem_dest;
	end

	assign wb_valid = mem_wb_reg_write && (mem_wb_dest != '0);  // r0 writes unreported
	assign wb_reg   = mem_wb_dest;
	assign wb_data  = mem_wb_data;
	assign halted   = mem_wb_is_halt || halted_q;

	a_no_wb_after_halt : assert property (@(posedge clk) disable iff (reset)
		!(wb_valid && halted));

	// HLT reached WB only after fetch was frozen
	a_halt_order : assert property (@(posedge clk) disable iff (reset)
		halted |-> halt_seen);

endmodule

// File: tb/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int NUM_PROGS   = 3;
	localparam int BODY_LEN    = 60;    // random instructions before HLT
	localparam int RUN_TIMEOUT = 2000;  // cycles from reset release to halted
	localparam int TAIL_CYCLES = 12;    // quiet cycles watched after halted

	logic      clk;
	logic      reset;
	logic      load_en;
	logic      load_dmem;
	mem_addr_t load_addr;
	word_t     load_data;
	logic      wb_valid;
	reg_addr_t wb_reg;
	word_t     wb_data;
	logic      halted;

	word_t     prog [MEM_DEPTH];
	word_t     dinit [MEM_DEPTH];  // data memory image for this program
	int        prog_len;           // words loaded into imem
	reg_addr_t exp_reg [$];        // model write-backs, program order
	word_t     exp_data [$];
	int        fail_count;
	int        wb_seen;

	cpu_core dut0 (
		.clk(clk), .reset(reset), .load_en(load_en), .load_dmem(load_dmem),
		.load_addr(load_addr), .load_data(load_data), .wb_valid(wb_valid),
		.wb_reg(wb_reg), .wb_data(wb_data), .halted(halted)
	);

	always #4 clk = ~clk;  // 8 ns period

	// **************************************************
	// failure handling and compare tasks
	// **************************************************
	task automatic stop_run();
		fail_count++;
		$display("Test failures found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_fail(input string msg);
		$display("Fail at time %0t: %s", $time, msg);
		stop_run();
	endtask

	// next model event against the report port
	task automatic check_wb(input reg_addr_t got_reg, input word_t got_data);
		reg_addr_t r;
		word_t     d;
		if (exp_reg.size() == 0) begin
			report_fail($sformatf("write-back r%0d=%h with no model event left",
				got_reg, got_data));
		end else begin
			r = exp_reg.pop_front();
			d = exp_data.pop_front();
			if (got_reg !== r || got_data !== d)
				report_fail($sformatf("write-back r%0d=%h, model r%0d=%h",
					got_reg, got_data, r, d));
		end
	endtask

	task automatic check_halted(input logic got, input logic exp);
		if (got !== exp)
			report_fail($sformatf("halted=%b, expected %b", got, exp));
	endtask

	// **************************************************
	// program generation
	// **************************************************
	// small pool so dependencies show up often, r0 included
	function automatic reg_addr_t pick_reg();
		if ($urandom_range(0, 3) != 0)
			return reg_addr_t'($urandom_range(0, 4));
		return reg_addr_t'($urandom_range(1, 15));
	endfunction

	task automatic build_program();
		reg_addr_t  rd, rs, rt;
		logic [3:0] off;
		logic [7:0] imm8;
		reg_addr_t  sw_base;
		logic [3:0] sw_off;
		logic       have_sw;
		int         kind;
		have_sw = 1'b0;
		sw_base = '0;
		sw_off  = '0;
		for (int i = 0; i < 4; i++)  // seed r1..r4 from dmem
			prog[i] = {OP_LW, reg_addr_t'(i + 1), 4'd0, reg_addr_t'($urandom_range(0, 15))};
		for (int i = 4; i < BODY_LEN; i++) begin
			rd   = pick_reg();
			rs   = pick_reg();
			rt   = pick_reg();
			off  = 4'($urandom_range(0, 15));
			imm8 = 8'($urandom_range(0, 255));
			kind = $urandom_range(0, 13);
			if (kind <= 6) begin
				prog[i] = {opcode_e'(kind[3:0]), rd, rs, rt};  // add..srl
			end else if (kind <= 9) begin
				if (have_sw && $urandom_range(0, 1) == 1) begin
					rs  = sw_base;  // reload a just-stored word
					off = sw_off;
				end
				prog[i] = {OP_LW, rd, rs, off};
			end else if (kind <= 11) begin
				prog[i] = {OP_SW, rd, rs, off};
				have_sw = 1'b1;
				sw_base = rs;
				sw_off  = off;
			end else if (kind == 12) begin
				prog[i] = {OP_LHB, rd, imm8};
			end else begin
				prog[i] = {OP_LLB, rd, imm8};
			end
		end
		prog[BODY_LEN]     = {OP_HLT, 12'h000};
		prog[BODY_LEN + 1] = NOP_INSTR;  // sits in IF/ID behind HLT
		prog_len = BODY_LEN + 2;
		for (int i = 0; i < MEM_DEPTH; i++)
			dinit[i] = word_t'($urandom());
	endtask

	// **************************************************
	// sequential reference model
	// **************************************************
	task automatic run_model();
		word_t     regs [16];
		word_t     dm [MEM_DEPTH];
		opcode_e   op;
		reg_addr_t rd, rs, rt;
		word_t     a, b, res, addr_sum;
		logic      writes;
		exp_reg.delete();
		exp_data.delete();
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		for (int i = 0; i < MEM_DEPTH; i++)
			dm[i] = dinit[i];
		for (int pc = 0; pc < BODY_LEN; pc++) begin
			op       = opcode_e'(prog[pc][15:12]);
			rd       = prog[pc][11:8];
			rs       = prog[pc][7:4];
			rt       = prog[pc][3:0];
			a        = regs[rs];
			b        = regs[rt];
			addr_sum = a + word_t'(rt);  // base + word offset for lw/sw
			res      = '0;
			writes   = 1'b1;
			case (op)
				OP_ADD: res = a + b;
				OP_SUB: res = a - b;
				OP_AND: res = a & b;
				OP_OR:  res = a | b;
				OP_XOR: res = a ^ b;
				OP_SLL: res = a << b[3:0];
				OP_SRL: res = a >> b[3:0];
				OP_LW:  res = dm[addr_sum[7:0]];
				OP_SW: begin
					dm[addr_sum[7:0]] = regs[rd];
					writes = 1'b0;
				end
				OP_LHB: res = {prog[pc][7:0], regs[rd][7:0]};
				OP_LLB: res = {regs[rd][15:8], prog[pc][7:0]};
				default: writes = 1'b0;
			endcase
			if (writes && rd != '0) begin  // r0 never written or reported
				regs[rd] = res;
				exp_reg.push_back(rd);
				exp_data.push_back(res);
			end
		end
	endtask

	// **************************************************
	// reset, load and run
	// **************************************************
	task automatic reset_and_load();
		@(posedge clk);
		reset <= 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		check_halted(halted, 1'b0);
		if (wb_valid !== 1'b0)
			report_fail("wb_valid high during reset");
		for (int i = 0; i < prog_len; i++) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_dmem <= 1'b0;
			load_addr <= mem_addr_t'(i);
			load_data <= prog[i];
		end
		for (int i = 0; i < MEM_DEPTH; i++) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_dmem <= 1'b1;
			load_addr <= mem_addr_t'(i);
			load_data <= dinit[i];
		end
		@(posedge clk);  // last word written on this edge
		load_en   <= 1'b0;
		load_dmem <= 1'b0;
		reset     <= 1'b0;
	endtask

	task automatic run_program(input int idx);
		int cycles;
		cycles  = 0;
		wb_seen = 0;
		while (halted !== 1'b1) begin
			@(negedge clk);  // outputs settled here
			cycles++;
			if (cycles > RUN_TIMEOUT) begin
				$display("timed out after %0d cycles waiting for halted in program %0d",
					RUN_TIMEOUT, idx);
				stop_run();
			end
			if (wb_valid !== 1'b0) begin
				check_wb(wb_reg, wb_data);
				wb_seen++;
			end
		end
		if (exp_reg.size() != 0)
			report_fail($sformatf("halted with %0d model write-backs outstanding",
				exp_reg.size()));
		repeat (TAIL_CYCLES) begin  // core must stay parked
			@(negedge clk);
			check_halted(halted, 1'b1);
			if (wb_valid !== 1'b0)
				report_fail("write-back reported after halted");
		end
		$display("program %0d retired %0d write-backs in %0d cycles", idx, wb_seen, cycles);
	endtask

	initial begin
		void'($urandom(32'hf825_c2ce));
		clk        = 1'b0;
		reset      = 1'b1;
		load_en    = 1'b0;
		load_dmem  = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		fail_count = 0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			build_program();
			run_model();
			reset_and_load();
			run_program(p);
		end
		if (fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "run ended with errors");
		end
	end

endmodule

// File: sources.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/forwarding_unit.sv
rtl/hazard_detection.sv
rtl/control_unit.sv
rtl/cpu_core.sv
tb/cpu_tb.sv

// File: Makefile
# Verilator build and run for the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
RTL_TOP   ?= cpu_core
FLAGS     ?= --assert --timing -Wno-fatal
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)

# status comes from grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
